//--- vlog.f
+incdir+src
src/perip_pkg.sv
src/dram_driver.sv
src/counter.sv
src/display_seg.sv
src/perip_bridge.sv
tb/perip_bridge_asserts.sv
tb/perip_bridge_tb.sv

//--- tb/perip_bridge_tb.sv
`timescale 1ns/1ps
`include "perip_defines.svh"

module perip_bridge_tb;
    import perip_pkg::*;

    localparam int PERIOD  = 100;
    localparam int TBL_LEN = 24;
    localparam int N_IN    = 6;
    localparam int N_RAND  = 8;
    localparam int N_SEG   = 12;
    localparam int TIMEOUT_CYCLES = 2 + TBL_LEN + 3 * N_IN + 3 * N_RAND + 24
        + 8 * `PERIP_CNT_DIV + N_SEG * 2 * `PERIP_SEG_SCAN_DIV + 100;

    localparam logic [31:0] ADDR_A = `PERIP_DRAM_BASE + 32'h100;
    localparam logic [31:0] ADDR_B = ADDR_A + 32'h4;

    // gfedcba for digits F down to 0
    localparam logic [15:0][6:0] SEG_FONT = {
        7'b1110001, 7'b1111001, 7'b1011110, 7'b0111001,
        7'b1111100, 7'b1110111, 7'b1101111, 7'b1111111,
        7'b0000111, 7'b1111101, 7'b1101101, 7'b1100110,
        7'b1001111, 7'b1011011, 7'b0000110, 7'b0111111
    };

    typedef struct packed {
        perip_req_t  req;
        logic        chk;
        logic [31:0] exp;
    } tbl_entry_t;

    logic        clk;
    logic        rst;
    perip_req_t  req;
    logic [63:0] sw;
    logic [7:0]  key;
    logic [31:0] rdata;
    logic [31:0] led;
    seg_bus_t    seg;

    logic [63:0] sw_next;
    logic [7:0]  key_next;
    logic        pend_chk;
    logic [31:0] pend_exp;
    logic [31:0] last_rdata;
    logic [31:0] rng;
    int          n_checks;
    int          n_errors;
    int          test_checks;
    int          test_errors;
    tbl_entry_t  tbl [TBL_LEN];
    dram_word_u  model [1 << `PERIP_DRAM_AW];
    logic [15:0] rand_idx [N_RAND];

    perip_bridge uut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .sw    (sw),
        .key   (key),
        .rdata (rdata),
        .led   (led),
        .seg   (seg)
    );

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("timeout after %0d cycles, the test sequence did not complete", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic perip_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
                                            input logic wen, input access_size_e size);
        perip_req_t r;
        r.addr  = addr;
        r.wdata = wdata;
        r.wen   = wen;
        r.size  = size;
        return r;
    endfunction

    // a write cycle returns zero on rdata
    function automatic tbl_entry_t write_entry(input logic [31:0] addr, input logic [31:0] data,
                                               input access_size_e size);
        return '{req: make_req(addr, data, 1'b1, size), chk: 1'b1, exp: 32'd0};
    endfunction

    function automatic tbl_entry_t read_entry(input logic [31:0] addr, input logic [31:0] exp);
        return '{req: make_req(addr, 32'd0, 1'b0, size_word), chk: 1'b1, exp: exp};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        test_checks++;
        assert (got === exp) else begin
            n_errors++;
            test_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        n_checks++;
        test_checks++;
        assert (ok) else begin
            n_errors++;
            test_errors++;
            $display("%s", msg);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // present one request, then check the read of the one before it
    task automatic issue(input perip_req_t r, input logic chk, input logic [31:0] exp);
        @(posedge clk);
        req <= r;
        sw  <= sw_next;
        key <= key_next;
        @(negedge clk);
        last_rdata = rdata;
        if (pend_chk) begin
            check_val("rdata", rdata, pend_exp);
        end
        pend_chk = chk;
        pend_exp = exp;
    endtask

    task automatic idle(input int n);
        repeat (n) issue(make_req(32'h0, 32'h0, 1'b0, size_word), 1'b0, 32'd0);
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] got);
        issue(make_req(addr, 32'h0, 1'b0, size_word), 1'b0, 32'd0);
        idle(1);
        got = last_rdata;
    endtask

    task automatic model_write(input logic [15:0] idx, input logic [1:0] off,
                               input access_size_e size, input logic [31:0] data);
        dram_word_u w;
        w = model[idx];
        case (size)
            size_byte: w.lanes[off] = data[7:0];
            size_half: begin
                w.lanes[{off[1], 1'b0}] = data[7:0];
                w.lanes[{off[1], 1'b1}] = data[15:8];
            end
            default: w.word = data;
        endcase
        model[idx] = w;
    endtask

    task automatic fill_table();
        tbl[0]  = read_entry(`PERIP_CNT_ADDR, 32'd0);
        tbl[1]  = write_entry(ADDR_A, 32'h1122_3344, size_word);
        tbl[2]  = read_entry(ADDR_A, 32'h1122_3344);
        tbl[3]  = write_entry(ADDR_A, 32'h0000_00AA, size_byte);
        tbl[4]  = write_entry(ADDR_A + 1, 32'h0000_00BB, size_byte);
        tbl[5]  = write_entry(ADDR_A + 2, 32'h0000_00CC, size_byte);
        tbl[6]  = write_entry(ADDR_A + 3, 32'hFFFF_FFDD, size_byte);
        tbl[7]  = write_entry(ADDR_B, 32'hCAFE_F00D, size_word);
        tbl[8]  = write_entry(ADDR_B, 32'h1234_5678, size_half);
        tbl[9]  = write_entry(ADDR_B + 2, 32'h0000_9ABC, size_half);
        tbl[10] = read_entry(ADDR_A, 32'hDDCC_BBAA);
        tbl[11] = read_entry(ADDR_B, 32'h9ABC_5678);
        tbl[12] = write_entry(`PERIP_DRAM_LAST, 32'h0BAD_BEEF, size_word);
        tbl[13] = read_entry(`PERIP_DRAM_LAST, 32'h0BAD_BEEF);
        tbl[14] = read_entry(32'h8014_0000, 32'd0);
        tbl[15] = read_entry(`PERIP_DRAM_LAST + 1, 32'd0);
        tbl[16] = write_entry(`PERIP_LED_ADDR, 32'h0000_A5A5, size_word);
        tbl[17] = read_entry(`PERIP_LED_ADDR, 32'd0);
        tbl[18] = write_entry(`PERIP_SEG_ADDR, 32'h1234_ABCD, size_word);
        tbl[19] = read_entry(`PERIP_SEG_ADDR, 32'h1234_ABCD);
        tbl[20] = read_entry(`PERIP_SW0_ADDR, 32'h89AB_CDEF);
        tbl[21] = read_entry(`PERIP_SW1_ADDR, 32'h0123_4567);
        tbl[22] = read_entry(`PERIP_KEY_ADDR, 32'h0000_005A);
        tbl[23] = read_entry(32'h8020_0100, 32'd0);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0]  c0;
        logic [31:0]  c1;
        logic [31:0]  v;
        logic [1:0]   off;
        logic [1:0]   seen;
        access_size_e sz;
        seg_lane_t    exp_lane;
        int           ph;

        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        sw = '0;
        key = '0;
        sw_next = 64'h0123_4567_89AB_CDEF;
        key_next = 8'h5A;
        pend_chk = 1'b0;
        pend_exp = '0;
        last_rdata = '0;
        rng = 32'h22070d4b;
        n_checks = 0;
        n_errors = 0;
        test_checks = 0;
        test_errors = 0;
        fill_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // dram lanes, registers and unmapped space
        for (int i = 0; i < TBL_LEN; i++) begin
            issue(tbl[i].req, tbl[i].chk, tbl[i].exp);
        end
        idle(1);
        check_val("led", led, 32'h0000_A5A5);
        end_test("table");

        for (int j = 0; j < N_IN; j++) begin
            rng = xorshift32(rng);
            sw_next[31:0] = rng;
            rng = xorshift32(rng);
            sw_next[63:32] = rng;
            rng = xorshift32(rng);
            key_next = rng[7:0];
            issue(make_req(`PERIP_SW0_ADDR, 32'h0, 1'b0, size_word), 1'b1, sw_next[31:0]);
            issue(make_req(`PERIP_SW1_ADDR, 32'h0, 1'b0, size_word), 1'b1, sw_next[63:32]);
            issue(make_req(`PERIP_KEY_ADDR, 32'h0, 1'b0, size_word), 1'b1, {24'd0, key_next});
        end
        idle(1);
        end_test("input reads");

        // whole words first so no lane stays unknown
        for (int j = 0; j < N_RAND; j++) begin
            rng = xorshift32(rng);
            rand_idx[j] = rng[15:0];
            rng = xorshift32(rng);
            model_write(rand_idx[j], 2'd0, size_word, rng);
            issue(make_req(`PERIP_DRAM_BASE + {14'd0, rand_idx[j], 2'b00}, rng, 1'b1, size_word),
                  1'b1, 32'd0);
        end
        for (int j = 0; j < N_RAND; j++) begin
            rng = xorshift32(rng);
            case (rng[9:8])
                2'd0: sz = size_byte;
                2'd1: sz = size_half;
                default: sz = size_word;
            endcase
            off = (sz == size_byte) ? rng[3:2] : (sz == size_half) ? {rng[3], 1'b0} : 2'd0;
            rng = xorshift32(rng);
            model_write(rand_idx[j], off, sz, rng);
            issue(make_req(`PERIP_DRAM_BASE + {14'd0, rand_idx[j], off}, rng, 1'b1, sz),
                  1'b1, 32'd0);
        end
        for (int j = 0; j < N_RAND; j++) begin
            issue(make_req(`PERIP_DRAM_BASE + {14'd0, rand_idx[j], 2'b00}, 32'h0, 1'b0, size_word),
                  1'b1, model[rand_idx[j]]);
        end
        idle(1);
        end_test("dram random");

        issue(make_req(`PERIP_CNT_ADDR, `PERIP_CNT_START, 1'b1, size_word), 1'b1, 32'd0);
        idle(`PERIP_CNT_DIV);
        read_word(`PERIP_CNT_ADDR, c0);
        repeat (3) begin
            idle(`PERIP_CNT_DIV);
            read_word(`PERIP_CNT_ADDR, c1);
            check_true(c1 > c0, $sformatf("FAIL count got %h expected above %h", c1, c0));
            c0 = c1;
        end
        issue(make_req(`PERIP_CNT_ADDR, `PERIP_CNT_STOP, 1'b1, size_word), 1'b1, 32'd0);
        read_word(`PERIP_CNT_ADDR, c0);
        idle(2 * `PERIP_CNT_DIV);
        // not a command so the count stays frozen
        issue(make_req(`PERIP_CNT_ADDR, 32'h1234_5678, 1'b1, size_word), 1'b1, 32'd0);
        read_word(`PERIP_CNT_ADDR, c1);
        check_val("count", c1, c0);
        issue(make_req(`PERIP_CNT_ADDR, `PERIP_CNT_START, 1'b1, size_word), 1'b1, 32'd0);
        read_word(`PERIP_CNT_ADDR, c1);
        check_true(c1 < c0, $sformatf("FAIL count got %h expected below %h", c1, c0));
        end_test("counter");

        rng = xorshift32(rng);
        v = rng;
        issue(make_req(`PERIP_SEG_ADDR, v, 1'b1, size_word), 1'b1, 32'd0);
        seen = 2'b00;
        for (int j = 0; j < N_SEG; j++) begin
            rng = xorshift32(rng);
            idle(int'(rng % (2 * `PERIP_SEG_SCAN_DIV)) + 1);
            ph = (seg[0].an == 2'b10) ? 1 : 0;
            seen[ph] = 1'b1;
            for (int k = 0; k < 4; k++) begin
                exp_lane.an  = ph ? 2'b10 : 2'b01;
                exp_lane.dp  = 1'b0;
                exp_lane.seg = SEG_FONT[v[8 * k + 4 * ph +: 4]];
                check_val($sformatf("seg[%0d]", k), {22'd0, seg[k]}, {22'd0, exp_lane});
            end
        end
        check_true(seen == 2'b11, "display did not alternate between both scan phases");
        end_test("display");

        // bound concurrent assertions
        check_true(uut.u_asserts.err_count == 0, "a bound assertion failed during the run");
        end_test("assertions");

        $display("checks %0d, passed %0d, failed %0d", n_checks, n_checks - n_errors, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tb/perip_bridge_asserts.sv
`timescale 1ns/1ps
`include "perip_defines.svh"

module perip_bridge_asserts (
    input logic                  clk,
    input logic                  rst,
    input perip_pkg::perip_req_t req,
    input logic                  dram_wen,
    input logic [31:0]           rdata,
    input perip_pkg::seg_bus_t   seg
);

    // number of assertion failures so far
    int err_count = 0;

    // first cycle out of reset reads as zero
    a_rdata_reset: assert property (@(posedge clk) $fell(rst) |-> (rdata == 32'd0))
        else begin
            err_count++;
            $error("rdata not zero in the cycle after reset release");
        end

    // inclusive dram range
    a_dram_strobe: assert property (@(posedge clk) disable iff (rst)
        dram_wen |-> (req.wen && (req.addr >= `PERIP_DRAM_BASE)
                      && (req.addr <= `PERIP_DRAM_LAST)))
        else begin
            err_count++;
            $error("dram write strobe high outside the dram range");
        end

    ////////////////////////////////////////
    // display lanes
    ////////////////////////////////////////

    for (genvar k = 0; k < 4; k++) begin : g_lane
        a_an_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(seg[k].an))
            else begin
                err_count++;
                $error("lane %0d anode select is not one-hot", k);
            end
        a_dp_off: assert property (@(posedge clk) disable iff (rst) seg[k].dp == 1'b0)
            else begin
                err_count++;
                $error("lane %0d decimal point is lit", k);
            end
    end

endmodule

bind perip_bridge perip_bridge_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .dram_wen (dram_wen),
    .rdata    (rdata),
    .seg      (seg)
);

//--- src/perip_bridge.sv
`timescale 1ns/1ps
`include "perip_defines.svh"

module perip_bridge (
    input  logic                  clk,
    input  logic                  rst,
    input  perip_pkg::perip_req_t req,
    input  logic [63:0]           sw,
    input  logic [7:0]            key,
    output logic [31:0]           rdata,
    output logic [31:0]           led,
    output perip_pkg::seg_bus_t   seg
);

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    logic sel_dram;
    logic sel_sw0;
    logic sel_sw1;
    logic sel_key;
    logic sel_seg;
    logic sel_led;
    logic sel_cnt;
    logic dram_wen;
    logic cnt_wen;

    assign sel_dram = (req.addr >= `PERIP_DRAM_BASE) && (req.addr <= `PERIP_DRAM_LAST);
    assign sel_sw0  = (req.addr == `PERIP_SW0_ADDR);
    assign sel_sw1  = (req.addr == `PERIP_SW1_ADDR);
    assign sel_key  = (req.addr == `PERIP_KEY_ADDR);
    assign sel_seg  = (req.addr == `PERIP_SEG_ADDR);
    assign sel_led  = (req.addr == `PERIP_LED_ADDR);
    assign sel_cnt  = (req.addr == `PERIP_CNT_ADDR);

    // sub-block strobes
    assign dram_wen = req.wen && sel_dram;
    assign cnt_wen  = req.wen && sel_cnt;

    ////////////////////////////////////////
    // led and segment registers
    ////////////////////////////////////////

    logic [31:0] seg_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led     <= '0;
            seg_reg <= '0;
        end else if (req.wen) begin
            if (sel_led) begin
                led <= req.wdata;
            end
            if (sel_seg) begin
                seg_reg <= req.wdata;
            end
        end
    end

    ////////////////////////////////////////
    // sub-blocks
    ////////////////////////////////////////

    logic [31:0] dram_rdata;
    logic [31:0] cnt_value;

    dram_driver u_dram (
        .clk       (clk),
        .word_addr (req.addr[`PERIP_DRAM_AW+1:2]),
        .byte_off  (req.addr[1:0]),
        .wdata     (req.wdata),
        .size      (req.size),
        .wen       (dram_wen),
        .rdata     (dram_rdata)
    );

    counter u_counter (
        .clk   (clk),
        .rst   (rst),
        .wdata (req.wdata),
        .wen   (cnt_wen),
        .count (cnt_value)
    );

    display_seg u_display (
        .clk   (clk),
        .rst   (rst),
        .value (seg_reg),
        .seg   (seg)
    );

    ////////////////////////////////////////
    // read path
    ////////////////////////////////////////

    logic [31:0] rd_next;

    // led is write-only and falls through to zero with unmapped space
    always_comb begin
        rd_next = '0;
        if (!req.wen) begin
            if (sel_dram) begin
                rd_next = dram_rdata;
            end else if (sel_sw0) begin
                rd_next = sw[31:0];
            end else if (sel_sw1) begin
                rd_next = sw[63:32];
            end else if (sel_key) begin
                rd_next = {24'd0, key};
            end else if (sel_seg) begin
                rd_next = seg_reg;
            end else if (sel_cnt) begin
                rd_next = cnt_value;
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= rd_next;
        end
    end

endmodule

//--- src/display_seg.sv
`timescale 1ns/1ps
`include "perip_defines.svh"

module display_seg (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         value,
    output perip_pkg::seg_bus_t seg
);
    import perip_pkg::*;

    localparam int SCAN_W = (`PERIP_SEG_SCAN_DIV > 1) ? $clog2(`PERIP_SEG_SCAN_DIV) : 1;
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`PERIP_SEG_SCAN_DIV - 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic              phase;

    // gfedcba, lit segment is 1
    function automatic logic [6:0] hex_to_seg(input logic [3:0] digit);
        logic [6:0] pat;
        case (digit)
            4'h0:    pat = 7'h3F;
            4'h1:    pat = 7'h06;
            4'h2:    pat = 7'h5B;
            4'h3:    pat = 7'h4F;
            4'h4:    pat = 7'h66;
            4'h5:    pat = 7'h6D;
            4'h6:    pat = 7'h7D;
            4'h7:    pat = 7'h07;
            4'h8:    pat = 7'h7F;
            4'h9:    pat = 7'h6F;
            4'hA:    pat = 7'h77;
            4'hB:    pat = 7'h7C;
            4'hC:    pat = 7'h39;
            4'hD:    pat = 7'h5E;
            4'hE:    pat = 7'h79;
            default: pat = 7'h71;
        endcase
        return pat;
    endfunction

    ////////////////////////////////////////
    // scan timing
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            phase    <= 1'b0;
        end else if (scan_cnt == SCAN_LAST) begin
            scan_cnt <= '0;
            phase    <= ~phase;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // lane outputs
    ////////////////////////////////////////

    // lane k owns byte k, phase picks its low or high nibble
    always_comb begin : lane_build
        seg_lane_t  lane;
        logic [3:0] nib;
        for (int k = 0; k < 4; k++) begin
            nib      = phase ? value[8*k+4 +: 4] : value[8*k +: 4];
            lane.an  = phase ? 2'b10 : 2'b01;
            lane.dp  = 1'b0;
            lane.seg = hex_to_seg(nib);
            seg[k]   = lane;
        end
    end

endmodule

//--- src/counter.sv
`timescale 1ns/1ps
`include "perip_defines.svh"

module counter (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] wdata,
    input  logic        wen,
    output logic [31:0] count
);

    localparam int PRESC_W = (`PERIP_CNT_DIV > 1) ? $clog2(`PERIP_CNT_DIV) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`PERIP_CNT_DIV - 1);

    logic               running;
    logic [PRESC_W-1:0] presc;
    logic               tick;
    logic               cmd_start;
    logic               cmd_stop;

    // anything other than the two commands is dropped
    assign cmd_start = wen && (wdata == `PERIP_CNT_START);
    assign cmd_stop  = wen && (wdata == `PERIP_CNT_STOP);

    assign tick = running && (presc == PRESC_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            presc   <= '0;
            count   <= '0;
        end else if (cmd_start) begin
            running <= 1'b1;
            presc   <= '0;
            count   <= '0;
        end else if (cmd_stop) begin
            running <= 1'b0;
        end else if (running) begin
            if (tick) begin
                presc <= '0;
                count <= count + 32'd1;
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

endmodule

//--- src/dram_driver.sv
`timescale 1ns/1ps
`include "perip_defines.svh"

module dram_driver (
    input  logic                      clk,
    input  logic [`PERIP_DRAM_AW-1:0] word_addr,
    input  logic [1:0]                byte_off,
    input  logic [31:0]               wdata,
    input  perip_pkg::access_size_e   size,
    input  logic                      wen,
    output logic [31:0]               rdata
);
    import perip_pkg::*;

    localparam int DEPTH = 1 << `PERIP_DRAM_AW;

    dram_word_u mem [DEPTH];
    dram_word_u wr_word;
    logic [3:0] lane_en;

    ////////////////////////////////////////
    // lane enables and write data
    ////////////////////////////////////////

    // low byte or halfword replicated so every enabled lane sees it
    always_comb begin
        case (size)
            size_byte: begin
                lane_en      = 4'b0001 << byte_off;
                wr_word.word = {4{wdata[7:0]}};
            end
            size_half: begin
                lane_en      = byte_off[1] ? 4'b1100 : 4'b0011;
                wr_word.word = {2{wdata[15:0]}};
            end
            default: begin
                lane_en      = 4'b1111;
                wr_word.word = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) begin
                    mem[word_addr].lanes[i] <= wr_word.lanes[i];
                end
            end
        end
    end

    // asynchronous read, the bridge registers it
    assign rdata = mem[word_addr].word;

endmodule

//--- src/perip_pkg.sv
package perip_pkg;

    ////////////////////////////////////////
    // bus request
    ////////////////////////////////////////

    // access width, only the dram looks at it
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_e;

    // one cpu access, presented for a single cycle
    typedef struct packed {
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic         wen;
        access_size_e size;
    } perip_req_t;

    ////////////////////////////////////////
    // dram storage
    ////////////////////////////////////////

    // same word seen whole or as byte lanes, lane 0 in the low bits
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } dram_word_u;

    ////////////////////////////////////////
    // display
    ////////////////////////////////////////

    // seg is gfedcba, an is one-hot and active high
    typedef struct packed {
        logic [1:0] an;
        logic       dp;
        logic [6:0] seg;
    } seg_lane_t;

    typedef seg_lane_t [3:0] seg_bus_t;

endpackage

//--- src/perip_defines.svh
`ifndef PERIP_DEFINES_SVH
`define PERIP_DEFINES_SVH

////////////////////////////////////////
// address map
////////////////////////////////////////

// dram range, both ends inclusive
`define PERIP_DRAM_BASE    32'h8010_0000
`define PERIP_DRAM_LAST    32'h8013_FFFC
`define PERIP_SW0_ADDR     32'h8020_0000
`define PERIP_SW1_ADDR     32'h8020_0004
`define PERIP_KEY_ADDR     32'h8020_0010
`define PERIP_SEG_ADDR     32'h8020_0020
`define PERIP_LED_ADDR     32'h8020_0040
`define PERIP_CNT_ADDR     32'h8020_0050

// word address bits of the ram, 64K words
`define PERIP_DRAM_AW      16

////////////////////////////////////////
// counter and display timing
////////////////////////////////////////

`define PERIP_CNT_START    32'h8000_0000
`define PERIP_CNT_STOP     32'hFFFF_FFFF
// clk cycles per count step
`define PERIP_CNT_DIV      4
// clk cycles per scan phase
`define PERIP_SEG_SCAN_DIV 8

`endif
